//--- hdl/noc_pkg.sv
// single-flit packets only; coordinates limit the mesh to 8x8 and port indices set rr scan order
package noc_pkg;

  // router ports
  localparam int NUM_PORTS = 5;

  typedef logic [2:0] port_idx_t;

  // one bit per port, indexed by the port constants below
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // index order is also the round-robin scan order
  localparam port_idx_t PORT_N = 3'd0;
  localparam port_idx_t PORT_S = 3'd1;
  localparam port_idx_t PORT_E = 3'd2;
  localparam port_idx_t PORT_W = 3'd3;
  localparam port_idx_t PORT_L = 3'd4;

  // mesh coordinate width, up to 8 by 8
  localparam int COORD_W = 3;

  // flit field widths
  localparam int PAYLOAD_W = 16;
  localparam int TAG_W     = 8;

  // 30 bit flit, destination in the top bits
  typedef struct packed {
    logic [COORD_W-1:0]   dst_x;
    logic [COORD_W-1:0]   dst_y;
    logic [TAG_W-1:0]     tag;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

//--- hdl/route_decode.sv
// XY dimension-order routing only; the destination is trusted to lie inside the mesh
`timescale 1ns/1ps

module route_decode #(
  parameter logic [noc_pkg::COORD_W-1:0] POS_X = '0,
  parameter logic [noc_pkg::COORD_W-1:0] POS_Y = '0
) (
  input  logic               clk,
  input  logic               valid_i,
  input  noc_pkg::flit_t     flit_i,
  output noc_pkg::port_vec_t req_o
);

  import noc_pkg::*;

  port_idx_t dir;

  // resolve x fully before moving in y
  always_comb begin
    if (flit_i.dst_x > POS_X) begin
      dir = PORT_E;
    end else if (flit_i.dst_x < POS_X) begin
      dir = PORT_W;
    end else if (flit_i.dst_y > POS_Y) begin
      dir = PORT_N;
    end else if (flit_i.dst_y < POS_Y) begin
      dir = PORT_S;
    end else begin
      // arrived, eject locally
      dir = PORT_L;
    end
  end

  // idle input requests nothing
  assign req_o = valid_i ? (port_vec_t'(1) << dir) : '0;

  // a valid flit asks for exactly one output
  a_req_onehot: assert property (
    @(posedge clk) valid_i |-> $onehot(req_o)
  ) else $error("route_decode: request not one-hot for valid flit");

endmodule

//--- hdl/rr_port_arbiter.sv
// one arbiter per output; grants at most one input per cycle and only while the output has room
`timescale 1ns/1ps

module rr_port_arbiter (
  input  logic               clk,
  input  logic               rst_i,
  input  noc_pkg::port_vec_t req_i,
  input  logic               room_i,
  output noc_pkg::port_vec_t grant_o
);

  import noc_pkg::*;

  port_idx_t ptr_q;
  port_idx_t win_idx;
  logic      win_found;

  // next port in scan order, wrapping L back to N
  function automatic port_idx_t next_idx(port_idx_t p);
    port_idx_t n;
    if (p == port_idx_t'(NUM_PORTS - 1)) begin
      n = PORT_N;
    end else begin
      n = p + port_idx_t'(1);
    end
    return n;
  endfunction

  // first requester at or after the pointer
  always_comb begin
    port_idx_t scan;
    scan      = ptr_q;
    win_idx   = ptr_q;
    win_found = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (!win_found && req_i[scan]) begin
        win_found = 1'b1;
        win_idx   = scan;
      end
      scan = next_idx(scan);
    end
  end

  // downstream room gates the grant, like a credit
  always_comb begin
    grant_o = '0;
    if (win_found && room_i) begin
      grant_o = port_vec_t'(1) << win_idx;
    end
  end

  // winner drops to lowest priority; pointer holds on idle or stall
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ptr_q <= PORT_N;
    end else if (win_found && room_i) begin
      ptr_q <= next_idx(win_idx);
    end
  end

  a_grant_onehot0: assert property (
    @(posedge clk) disable iff (rst_i)
    $onehot0(grant_o)
  ) else $error("rr_port_arbiter: more than one grant");

  a_grant_in_req: assert property (
    @(posedge clk) disable iff (rst_i)
    (grant_o & ~req_i) == '0
  ) else $error("rr_port_arbiter: grant to a non-requesting input");

  a_grant_needs_room: assert property (
    @(posedge clk) disable iff (rst_i)
    !room_i |-> (grant_o == '0)
  ) else $error("rr_port_arbiter: grant while output has no room");

endmodule

//--- hdl/output_stage.sv
// one-entry output register; the arbiter must only grant when room_o is high
`timescale 1ns/1ps

module output_stage (
  input  logic                                    clk,
  input  logic                                    rst_i,
  input  noc_pkg::port_vec_t                      grant_i,
  input  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] flits_i,
  input  logic                                    out_ready_i,
  output logic                                    room_o,
  output logic                                    out_valid_o,
  output noc_pkg::flit_t                          out_flit_o
);

  import noc_pkg::*;

  logic  valid_q;
  flit_t flit_q;
  flit_t sel_flit;
  logic  load;

  // empty, or draining this cycle
  assign room_o = !valid_q || out_ready_i;
  assign load   = |grant_i;

  // crossbar column, grant is one-hot
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant_i[i]) begin
        sel_flit = flits_i[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // load and drain may coincide for back-to-back flits
  always_ff @(posedge clk) begin
    if (load) begin
      flit_q <= sel_flit;
    end
  end

  assign out_valid_o = valid_q;
  assign out_flit_o  = flit_q;

  // stalled flit stays put until taken
  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst_i)
    (valid_q && !out_ready_i) |=> (valid_q && flit_q == $past(flit_q))
  ) else $error("output_stage: held flit changed under back-pressure");

  // arbiter must respect the room this stage reports
  a_load_with_room: assert property (
    @(posedge clk) disable iff (rst_i)
    load |-> room_o
  ) else $error("output_stage: flit loaded into a full register");

endmodule

//--- hdl/router_switch.sv
// switch allocation and crossbar only: no VCs, no input buffers, any input may reach any output
`timescale 1ns/1ps

module router_switch #(
  parameter logic [noc_pkg::COORD_W-1:0] POS_X = '0,
  parameter logic [noc_pkg::COORD_W-1:0] POS_Y = '0
) (
  input  logic                                    clk,
  input  logic                                    rst_i,
  input  noc_pkg::port_vec_t                      in_valid_i,
  input  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] in_flit_i,
  output noc_pkg::port_vec_t                      in_ready_o,
  input  noc_pkg::port_vec_t                      out_ready_i,
  output noc_pkg::port_vec_t                      out_valid_o,
  output noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] out_flit_o
);

  import noc_pkg::*;

  // in_req[p]: outputs wanted by input p
  port_vec_t in_req  [NUM_PORTS];
  // out_req[q]: inputs wanting output q
  port_vec_t out_req [NUM_PORTS];
  port_vec_t grant   [NUM_PORTS];
  port_vec_t room;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
    route_decode #(
      .POS_X (POS_X),
      .POS_Y (POS_Y)
    ) u_decode (
      .clk     (clk),
      .valid_i (in_valid_i[p]),
      .flit_i  (in_flit_i[p]),
      .req_o   (in_req[p])
    );
  end

  // requests by input to requests by output
  always_comb begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        out_req[q][p] = in_req[p][q];
      end
    end
  end

  for (genvar q = 0; q < NUM_PORTS; q++) begin : g_out
    rr_port_arbiter u_arb (
      .clk     (clk),
      .rst_i   (rst_i),
      .req_i   (out_req[q]),
      .room_i  (room[q]),
      .grant_o (grant[q])
    );

    output_stage u_stage (
      .clk         (clk),
      .rst_i       (rst_i),
      .grant_i     (grant[q]),
      .flits_i     (in_flit_i),
      .out_ready_i (out_ready_i[q]),
      .room_o      (room[q]),
      .out_valid_o (out_valid_o[q]),
      .out_flit_o  (out_flit_o[q])
    );
  end

  // each input targets one output, so at most one grant bit is set
  always_comb begin
    in_ready_o = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        in_ready_o[p] = in_ready_o[p] | grant[q][p];
      end
    end
  end

endmodule

//--- sim/router_switch_tb.sv
// router at (3,4) under single-flit random traffic; tags carry the source in bits 7:5
`timescale 1ns/1ps

module router_switch_tb;

  import noc_pkg::*;

  localparam int                 CLK_PERIOD = 40;
  localparam int                 NUM_FLITS  = 2000;
  localparam int                 FAIR_FLITS = 50;
  localparam logic [31:0]        SEED       = 32'h83061de8;
  localparam logic [COORD_W-1:0] MY_X       = 3'd3;
  localparam logic [COORD_W-1:0] MY_Y       = 3'd4;

  // error categories
  localparam int E_RESET = 0;
  localparam int E_ROUTE = 1;
  localparam int E_DATA  = 2;
  localparam int E_ARB   = 3;
  localparam int E_STALL = 4;

  logic                  clk;
  logic                  rst_i;
  port_vec_t             in_valid;
  flit_t [NUM_PORTS-1:0] in_flit;
  port_vec_t             in_ready;
  port_vec_t             out_ready;
  port_vec_t             out_valid;
  flit_t [NUM_PORTS-1:0] out_flit;

  // model state with one queue per (output, source) pair
  flit_t     exp_q [NUM_PORTS*NUM_PORTS][$];
  port_idx_t rr_ptr [NUM_PORTS];
  port_vec_t model_full;
  port_vec_t taken;
  port_vec_t stall_prev;
  flit_t     stall_flit [NUM_PORTS];
  logic [4:0] seq [NUM_PORTS];
  int        err_cnt [5];
  int        phase;
  int        accepted;
  int        fair_next;
  int        parallel_hits;
  logic      first_cycle;

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  router_switch #(
    .POS_X (MY_X),
    .POS_Y (MY_Y)
  ) dut0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .in_ready_o  (in_ready),
    .out_ready_i (out_ready),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit)
  );

  // dimension order with x first
  function automatic port_idx_t xy_route(flit_t f);
    port_idx_t d;
    if (f.dst_x > MY_X) d = PORT_E;
    else if (f.dst_x < MY_X) d = PORT_W;
    else if (f.dst_y > MY_Y) d = PORT_N;
    else if (f.dst_y < MY_Y) d = PORT_S;
    else d = PORT_L;
    return d;
  endfunction

  // first requester counting up from the pointer, modulo the port count
  function automatic port_idx_t rr_pick(port_vec_t req, port_idx_t ptr);
    int cand;
    int pick;
    pick = -1;
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = (int'(ptr) + k) % NUM_PORTS;
      if (pick < 0 && req[cand]) pick = cand;
    end
    return port_idx_t'(pick);
  endfunction

  task automatic value_error(input int cat, input string test,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    err_cnt[cat]++;
    $display("FAILED %s expected %h actual %h", test, exp_v, act_v);
  endtask

  task automatic plain_error(input int cat, input string what);
    err_cnt[cat]++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic print_counts();
    $display("errors: reset %0d, routing %0d, data %0d, arbitration %0d, back-pressure %0d",
             err_cnt[E_RESET], err_cnt[E_ROUTE], err_cnt[E_DATA], err_cnt[E_ARB],
             err_cnt[E_STALL]);
  endtask

  // new flit for input p with a destination shaped by the phase
  task automatic next_flit(input int p);
    flit_t f;
    f = '0;
    f.tag     = {3'(p), seq[p]};
    f.payload = 16'($urandom);
    seq[p]    = seq[p] + 5'd1;
    if (phase == 0) begin
      f.dst_x = MY_X;
      f.dst_y = MY_Y;
    end else if (phase == 1) begin
      // input p aims at output p
      f.dst_x = MY_X;
      f.dst_y = MY_Y;
      case (port_idx_t'(p))
        PORT_N: f.dst_y = 3'd6;
        PORT_S: f.dst_y = 3'd1;
        PORT_E: f.dst_x = 3'd6;
        PORT_W: f.dst_x = 3'd0;
        default: f.dst_x = MY_X;
      endcase
    end else begin
      if ($urandom % 2 == 0) f.dst_x = MY_X;
      else f.dst_x = 3'($urandom % 8);
      f.dst_y = 3'($urandom % 8);
    end
    in_flit[p]  <= f;
    in_valid[p] <= 1'b1;
  endtask

  // called on the rising edge; a sender holds its flit until taken
  task automatic drive_inputs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (!in_valid[p] || taken[p]) begin
        if (phase == 3 || (phase == 2 && $urandom % 4 == 0)) in_valid[p] <= 1'b0;
        else next_flit(p);
      end
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (phase == 2) out_ready[q] <= ($urandom % 4 != 0);
      else out_ready[q] <= 1'b1;
    end
  endtask

  task automatic check_outputs();
    flit_t f;
    int    src;
    int    qi;
    if (out_valid !== model_full) value_error(E_DATA, "out_valid", 32'(model_full),
                                              32'(out_valid));
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (stall_prev[q] && (!out_valid[q] || out_flit[q] !== stall_flit[q]))
        value_error(E_STALL, "stalled flit", 32'(stall_flit[q]), 32'(out_flit[q]));
      stall_prev[q] = out_valid[q] && !out_ready[q];
      stall_flit[q] = out_flit[q];
      if (out_valid[q] && out_ready[q]) begin
        f   = out_flit[q];
        src = int'(f.tag[7:5]);
        if (int'(xy_route(f)) != q) value_error(E_ROUTE, "xy route", 32'(q), 32'(xy_route(f)));
        if (src >= NUM_PORTS) begin
          plain_error(E_DATA, "output flit carries an unknown source in its tag");
        end else begin
          qi = q * NUM_PORTS + src;
          if (exp_q[qi].size() == 0) begin
            plain_error(E_DATA, "flit left an output although none was expected from its source");
          end else begin
            if (f !== exp_q[qi][0]) value_error(E_DATA, "flit order", 32'(exp_q[qi][0]), 32'(f));
            void'(exp_q[qi].pop_front());
          end
        end
      end
    end
  endtask

  task automatic check_arbitration();
    port_vec_t req [NUM_PORTS];
    port_vec_t exp_ready;
    port_vec_t single_req;
    port_idx_t win;
    port_idx_t dst;
    int        single_cnt;
    exp_ready  = '0;
    single_req = '0;
    single_cnt = 0;
    for (int q = 0; q < NUM_PORTS; q++) req[q] = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (in_valid[p]) begin
        dst = xy_route(in_flit[p]);
        req[dst][p] = 1'b1;
      end
    end
    for (int q = 0; q < NUM_PORTS; q++) begin
      if (req[q] != '0 && (!model_full[q] || out_ready[q])) begin
        win = rr_pick(req[q], rr_ptr[q]);
        exp_ready[win] = 1'b1;
        rr_ptr[q] = port_idx_t'((int'(win) + 1) % NUM_PORTS);
        model_full[q] = 1'b1;
        if ($countones(req[q]) == 1) begin
          single_cnt++;
          single_req |= req[q];
        end
        // full load on local cycles N, S, E, W, L over and over
        if (phase == 0 && q == int'(PORT_L)) begin
          if (in_ready !== (port_vec_t'(1) << fair_next))
            value_error(E_ARB, "round robin order", 32'(port_vec_t'(1) << fair_next),
                        32'(in_ready));
          fair_next = (fair_next + 1) % NUM_PORTS;
        end
      end else if (out_ready[q]) begin
        model_full[q] = 1'b0;
      end
    end
    if (first_cycle && in_ready !== 5'b00001)
      value_error(E_ARB, "first grant after reset", 32'd1, 32'(in_ready));
    first_cycle = 1'b0;
    if (in_ready !== exp_ready) value_error(E_ARB, "grant pattern", 32'(exp_ready), 32'(in_ready));
    if (single_cnt >= 2) begin
      parallel_hits++;
      if ((in_ready & single_req) != single_req)
        value_error(E_ARB, "parallel accept", 32'(single_req), 32'(in_ready & single_req));
    end
    taken = in_valid & in_ready;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (taken[p]) begin
        dst = xy_route(in_flit[p]);
        if (out_valid[dst] && !out_ready[dst])
          plain_error(E_STALL, "input accepted toward an output that is full and stalled");
        exp_q[int'(dst) * NUM_PORTS + p].push_back(in_flit[p]);
        accepted++;
      end
    end
  endtask

  // sampled mid-cycle so transfers happen at the next rising edge
  always @(negedge clk) begin
    if (rst_i) begin
      if (out_valid !== '0) plain_error(E_RESET, "out_valid high during reset");
      taken      = '0;
      model_full = '0;
      stall_prev = '0;
      for (int q = 0; q < NUM_PORTS; q++) rr_ptr[q] = PORT_N;
    end else begin
      check_outputs();
      check_arbitration();
    end
  end

  initial begin
    #(CLK_PERIOD * 20 * NUM_FLITS);
    $display("timeout: traffic did not finish within %0d ns", CLK_PERIOD * 20 * NUM_FLITS);
    print_counts();
    $display("Checks failed");
    $finish;
  end

  initial begin
    int left;
    int total;
    void'($urandom(SEED));
    rst_i         = 1'b1;
    in_valid      = '0;
    in_flit       = '0;
    out_ready     = '1;
    taken         = '0;
    phase         = 0;
    accepted      = 0;
    fair_next     = 0;
    parallel_hits = 0;
    first_cycle   = 1'b1;
    for (int i = 0; i < 5; i++) err_cnt[i] = 0;
    for (int p = 0; p < NUM_PORTS; p++) seq[p] = '0;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    // full load on local from the first cycle out of reset
    drive_inputs();
    while (accepted < FAIR_FLITS) begin
      @(posedge clk);
      drive_inputs();
    end
    phase = 1;
    repeat (30) begin
      @(posedge clk);
      drive_inputs();
    end
    phase = 2;
    while (accepted < NUM_FLITS) begin
      @(posedge clk);
      drive_inputs();
    end
    // drain with senders dropping valid once taken and outputs always ready
    phase = 3;
    do begin
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
    end while (in_valid != '0 || out_valid != '0);
    @(posedge clk);
    left = 0;
    for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) left += exp_q[i].size();
    if (left != 0) plain_error(E_DATA, "flits were accepted but never left the router");
    if (parallel_hits == 0) plain_error(E_ARB, "two outputs never accepted in the same cycle");
    total = 0;
    for (int i = 0; i < 5; i++) total += err_cnt[i];
    print_counts();
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb.f
hdl/noc_pkg.sv
hdl/route_decode.sv
hdl/rr_port_arbiter.sv
hdl/output_stage.sv
hdl/router_switch.sv
sim/router_switch_tb.sv

//--- Makefile
# Verilator build and run for the router switch testbench

SRCS = hdl/noc_pkg.sv hdl/route_decode.sv hdl/rr_port_arbiter.sv \
       hdl/output_stage.sv hdl/router_switch.sv sim/router_switch_tb.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vrouter_switch_tb: tb.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module router_switch_tb \
	  -f tb.f -o Vrouter_switch_tb

# pass only if the log holds the pass line
run: obj_dir/Vrouter_switch_tb
	./obj_dir/Vrouter_switch_tb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
